/* hw/txPkg.sv */
`default_nettype none

package txPkg;

    localparam int dataBitSize = 16;
    localparam int averagingExpBitSize = 4; // exponents 0 to 12 in use
    localparam int channelIdBitSize = 4;
    localparam int burstLenBitSize = 12;

    // one word of the transmit bus, read as a header or as a sample
    typedef union packed {
        struct packed {
            logic [channelIdBitSize-1:0] channelId;
            logic [burstLenBitSize-1:0] burstLen;
        } header;
        logic signed [dataBitSize-1:0] data;
    } txWord_t;

endpackage

`default_nettype wire

/* hw/sampleAverager.sv */
`timescale 1ns/1ns
`default_nettype none

module sampleAverager (
    input  logic dataClk,
    input  logic rst,
    input  logic enableData,
    input  logic [txPkg::averagingExpBitSize-1:0] averagingExp,
    input  logic signed [txPkg::dataBitSize-1:0] in,
    output logic signed [txPkg::dataBitSize-1:0] averagedData,
    output logic averagedValid
);

    localparam int cntWidth = 2 ** txPkg::averagingExpBitSize;
    localparam int accWidth = txPkg::dataBitSize + cntWidth;

    logic [txPkg::averagingExpBitSize-1:0] runExp;
    logic [txPkg::averagingExpBitSize-1:0] curExp;
    logic [cntWidth-1:0] sampleCount;
    logic [cntWidth-1:0] lastIndex;
    logic signed [accWidth-1:0] acc;
    logic signed [accWidth-1:0] sum;
    logic signed [accWidth-1:0] shifted;
    logic lastSample;

    // the exponent is taken live on the first sample and held for the rest of the run
    assign curExp = (sampleCount == '0) ? averagingExp : runExp;
    assign lastIndex = ~({cntWidth{1'b1}} << curExp); // 2^exp - 1
    assign lastSample = (sampleCount == lastIndex);

    assign sum = acc + in; // in is sign extended to the accumulator width
    assign shifted = sum >>> curExp; // floor division, rounds toward minus infinity

    always_ff @(posedge dataClk) begin
        if (rst) begin
            acc <= '0;
            sampleCount <= '0;
            averagedValid <= 1'b0;
        end else if (enableData) begin
            if (lastSample) begin
                acc <= '0; // next run may start on the very next sample
                sampleCount <= '0;
                averagedValid <= 1'b1;
            end else begin
                acc <= sum;
                sampleCount <= sampleCount + 1'b1;
                averagedValid <= 1'b0;
            end
        end else begin
            acc <= '0; // a partial run is thrown away
            sampleCount <= '0;
            averagedValid <= 1'b0;
        end
    end

    always_ff @(posedge dataClk) begin
        if (enableData && sampleCount == '0) begin
            runExp <= averagingExp;
        end
        if (enableData && lastSample) begin
            averagedData <= shifted[txPkg::dataBitSize-1:0]; // truncated mean
        end
    end

endmodule

`default_nettype wire

/* hw/asyncSampleFifo.sv */
`timescale 1ns/1ns
`default_nettype none

module asyncSampleFifo #(
    parameter int dataWidth = 16,
    parameter int depthLog2 = 6
) (
    input  logic dataClk,
    input  logic fifoReadClk,
    input  logic rst,
    input  logic writeEnable,
    input  logic [dataWidth-1:0] writeData,
    input  logic readRequest,
    output logic [dataWidth-1:0] dataRead,
    output logic readEmpty,
    output logic [depthLog2:0] readUsed,
    output logic overflow
);

    localparam int ptrWidth = depthLog2 + 1;

    logic [dataWidth-1:0] mem [0:(2**depthLog2)-1];

    logic [ptrWidth-1:0] wrBin;
    logic [ptrWidth-1:0] wrBinNext;
    logic [ptrWidth-1:0] wrGray;
    logic [ptrWidth-1:0] rdGraySync1;
    logic [ptrWidth-1:0] rdGraySync2;
    logic writeFull;

    logic [ptrWidth-1:0] rdBin;
    logic [ptrWidth-1:0] rdBinNext;
    logic [ptrWidth-1:0] rdGray;
    logic [ptrWidth-1:0] wrGraySync1;
    logic [ptrWidth-1:0] wrGraySync2;
    logic [ptrWidth-1:0] wrBinSync;

    function automatic logic [ptrWidth-1:0] grayToBin(input logic [ptrWidth-1:0] gray);
        logic [ptrWidth-1:0] bin;
        bin[ptrWidth-1] = gray[ptrWidth-1];
        for (int i = ptrWidth - 2; i >= 0; i--) begin
            bin[i] = bin[i+1] ^ gray[i];
        end
        return bin;
    endfunction

    assign wrBinNext = wrBin + 1'b1;
    // full when the pointers differ only in the two top Gray bits
    assign writeFull = (wrGray == (rdGraySync2 ^ {2'b11, {(ptrWidth-2){1'b0}}}));

    always_ff @(posedge dataClk) begin
        if (rst) begin
            wrBin <= '0;
            wrGray <= '0;
            rdGraySync1 <= '0;
            rdGraySync2 <= '0;
            overflow <= 1'b0;
        end else begin
            rdGraySync1 <= rdGray;
            rdGraySync2 <= rdGraySync1;
            if (writeEnable) begin
                if (writeFull) begin
                    overflow <= 1'b1; // sticky until reset
                end else begin
                    wrBin <= wrBinNext;
                    wrGray <= wrBinNext ^ (wrBinNext >> 1);
                end
            end
        end
    end

    always_ff @(posedge dataClk) begin
        if (writeEnable && !writeFull) begin
            mem[wrBin[depthLog2-1:0]] <= writeData;
        end
    end

    assign rdBinNext = rdBin + 1'b1;
    assign wrBinSync = grayToBin(wrGraySync2);
    assign readEmpty = (rdGray == wrGraySync2);
    assign readUsed = wrBinSync - rdBin;

    always_ff @(posedge fifoReadClk) begin
        if (rst) begin
            rdBin <= '0;
            rdGray <= '0;
            wrGraySync1 <= '0;
            wrGraySync2 <= '0;
        end else begin
            wrGraySync1 <= wrGray;
            wrGraySync2 <= wrGraySync1;
            if (readRequest && !readEmpty) begin
                rdBin <= rdBinNext;
                rdGray <= rdBinNext ^ (rdBinNext >> 1);
            end
        end
    end

    always_ff @(posedge fifoReadClk) begin
        if (readRequest && !readEmpty) begin
            dataRead <= mem[rdBin[depthLog2-1:0]]; // not show-ahead
        end
    end

endmodule

`default_nettype wire

/* hw/channelDataHandler.sv */
`timescale 1ns/1ns
`default_nettype none

module channelDataHandler #(
    parameter int fifoDepthLog2 = 6
) (
    input  logic dataClk,
    input  logic fifoReadClk,
    input  logic rst,
    input  logic enableData,
    input  logic [txPkg::averagingExpBitSize-1:0] averagingExp,
    input  logic signed [txPkg::dataBitSize-1:0] in,
    input  logic readRequest,
    output logic [txPkg::dataBitSize-1:0] dataRead,
    output logic readEmpty,
    output logic [fifoDepthLog2:0] readUsed,
    output logic overflow
);

    logic signed [txPkg::dataBitSize-1:0] averagedData;
    logic averagedValid;

    sampleAverager sampleAverager_i (
        .dataClk       (dataClk),
        .rst           (rst),
        .enableData    (enableData),
        .averagingExp  (averagingExp),
        .in            (in),
        .averagedData  (averagedData),
        .averagedValid (averagedValid)
    );

    asyncSampleFifo #(
        .dataWidth (txPkg::dataBitSize),
        .depthLog2 (fifoDepthLog2)
    ) asyncSampleFifo_i (
        .dataClk     (dataClk),
        .fifoReadClk (fifoReadClk),
        .rst         (rst),
        .writeEnable (averagedValid), // every average is queued
        .writeData   (averagedData),
        .readRequest (readRequest),
        .dataRead    (dataRead),
        .readEmpty   (readEmpty),
        .readUsed    (readUsed),
        .overflow    (overflow)
    );

endmodule

`default_nettype wire

/* hw/transmitArbiter.sv */
`timescale 1ns/1ns
`default_nettype none

module transmitArbiter #(
    parameter int nOfChannels = 4,
    parameter int fifoDepthLog2 = 6,
    parameter int maxBurst = 8
) (
    input  logic fifoReadClk,
    input  logic rst,
    input  logic [nOfChannels-1:0] readEmpty,
    input  logic [nOfChannels*(fifoDepthLog2+1)-1:0] readUsed,
    input  logic [nOfChannels*txPkg::dataBitSize-1:0] dataRead,
    output logic [nOfChannels-1:0] readRequest,
    output txPkg::txWord_t txWord,
    output logic txValid,
    output logic txHeader
);

    localparam int chanWidth = $clog2(nOfChannels);
    localparam int usedWidth = fifoDepthLog2 + 1;
    localparam int burstWidth = $clog2(maxBurst + 1);

    localparam logic [1:0] IDLE = 2'd0;
    localparam logic [1:0] HEADER = 2'd1;
    localparam logic [1:0] BURST = 2'd2;

    logic [1:0] state;
    logic [chanWidth-1:0] lastServed;
    logic [chanWidth-1:0] sel;
    logic [chanWidth-1:0] pick;
    logic found;
    logic [usedWidth-1:0] pickUsed;
    logic [burstWidth-1:0] burstLen;
    logic [burstWidth-1:0] reqCount;
    logic [burstWidth-1:0] sentCount;

    // first non-empty channel after the one served last
    always_comb begin
        int cand;
        found = 1'b0;
        pick = lastServed;
        for (int k = 1; k <= nOfChannels; k++) begin
            cand = (int'(lastServed) + k) % nOfChannels;
            if (!found && !readEmpty[cand]) begin
                found = 1'b1;
                pick = chanWidth'(cand);
            end
        end
    end

    assign pickUsed = readUsed[pick*usedWidth +: usedWidth];

    always_ff @(posedge fifoReadClk) begin
        if (rst) begin
            state <= IDLE;
            lastServed <= chanWidth'(nOfChannels - 1); // channel 0 goes first
            sel <= '0;
            burstLen <= '0;
            reqCount <= '0;
            sentCount <= '0;
        end else begin
            case (state)
                IDLE: begin
                    if (found) begin
                        sel <= pick;
                        burstLen <= (pickUsed > maxBurst) ? burstWidth'(maxBurst)
                                                          : burstWidth'(pickUsed);
                        state <= HEADER;
                    end
                end
                HEADER: begin
                    reqCount <= 1; // first request goes out with the header
                    sentCount <= '0;
                    state <= BURST;
                end
                BURST: begin
                    if (reqCount < burstLen) begin
                        reqCount <= reqCount + 1'b1;
                    end
                    sentCount <= sentCount + 1'b1;
                    if (sentCount + 1'b1 == burstLen) begin
                        lastServed <= sel;
                        state <= IDLE;
                    end
                end
                default: state <= IDLE;
            endcase
        end
    end

    // data words leave one cycle after their request, straight from the FIFO register
    always_comb begin
        txWord = '0;
        txValid = 1'b0;
        txHeader = 1'b0;
        readRequest = '0;
        case (state)
            HEADER: begin
                txWord.header.channelId = txPkg::channelIdBitSize'(sel);
                txWord.header.burstLen = txPkg::burstLenBitSize'(burstLen);
                txValid = 1'b1;
                txHeader = 1'b1;
                readRequest[sel] = 1'b1;
            end
            BURST: begin
                txWord.data = dataRead[sel*txPkg::dataBitSize +: txPkg::dataBitSize];
                txValid = 1'b1;
                readRequest[sel] = (reqCount < burstLen);
            end
            default: ;
        endcase
    end

endmodule

`default_nettype wire

/* hw/transmissionTop.sv */
`timescale 1ns/1ns
`default_nettype none

module transmissionTop #(
    parameter int nOfChannels = 4,
    parameter int fifoDepthLog2 = 6,
    parameter int maxBurst = 8
) (
    input  logic dataClk,
    input  logic fifoReadClk,
    input  logic rst,
    input  logic [nOfChannels-1:0] enableData,
    input  logic [txPkg::averagingExpBitSize-1:0] averagingExp,
    input  logic [nOfChannels*txPkg::dataBitSize-1:0] in,
    output txPkg::txWord_t txWord,
    output logic txValid,
    output logic txHeader,
    output logic [nOfChannels-1:0] overflow
);

    localparam int usedWidth = fifoDepthLog2 + 1;

    logic [nOfChannels-1:0] readRequest;
    logic [nOfChannels-1:0] readEmpty;
    logic [nOfChannels*usedWidth-1:0] readUsed;
    logic [nOfChannels*txPkg::dataBitSize-1:0] dataRead;

    for (genvar i = 0; i < nOfChannels; i++) begin : gChannel
        channelDataHandler #(
            .fifoDepthLog2 (fifoDepthLog2)
        ) channelDataHandler_i (
            .dataClk      (dataClk),
            .fifoReadClk  (fifoReadClk),
            .rst          (rst),
            .enableData   (enableData[i]),
            .averagingExp (averagingExp), // shared by all channels
            .in           (in[i*txPkg::dataBitSize +: txPkg::dataBitSize]),
            .readRequest  (readRequest[i]),
            .dataRead     (dataRead[i*txPkg::dataBitSize +: txPkg::dataBitSize]),
            .readEmpty    (readEmpty[i]),
            .readUsed     (readUsed[i*usedWidth +: usedWidth]),
            .overflow     (overflow[i])
        );
    end

    transmitArbiter #(
        .nOfChannels   (nOfChannels),
        .fifoDepthLog2 (fifoDepthLog2),
        .maxBurst      (maxBurst)
    ) transmitArbiter_i (
        .fifoReadClk (fifoReadClk),
        .rst         (rst),
        .readEmpty   (readEmpty),
        .readUsed    (readUsed),
        .dataRead    (dataRead),
        .readRequest (readRequest),
        .txWord      (txWord),
        .txValid     (txValid),
        .txHeader    (txHeader)
    );

endmodule

`default_nettype wire

/* tb/transmissionTop_tb.sv */
`timescale 1ns/1ns
`default_nettype none

module transmissionTop_tb;

    localparam int nOfChannels = 4;
    localparam int fifoDepthLog2 = 6;
    localparam int maxBurst = 8;
    localparam int maxAvg = 1024;
    localparam int visibleLag = 6; // data cycles from a run's last sample to a readable FIFO word

    logic dataClk = 1'b0;
    logic fifoReadClk = 1'b0;
    logic rst;
    logic [nOfChannels-1:0] enableData;
    logic [txPkg::averagingExpBitSize-1:0] averagingExp;
    logic [nOfChannels*txPkg::dataBitSize-1:0] in;
    txPkg::txWord_t txWord;
    logic txValid;
    logic txHeader;
    logic [nOfChannels-1:0] overflow;

    int errors = 0;
    int testsRun = 0;
    int cycle = 0;
    string testName;
    logic [nOfChannels-1:0] mask;
    logic checkValues;
    int nAvg;
    int baseV [nOfChannels];
    int stepV [nOfChannels];
    logic signed [15:0] expVal [nOfChannels][maxAvg];
    int runEnd [maxAvg]; // drive cycle of each run's last sample as shared by all channels
    int recvCount [nOfChannels];
    logic [nOfChannels-1:0] busySnap [nOfChannels];
    logic [nOfChannels-1:0] seenSince [nOfChannels];
    logic [nOfChannels-1:0] hadPacket;
    int remaining = 0;
    int curCh = 0;

    transmissionTop #(
        .nOfChannels   (nOfChannels),
        .fifoDepthLog2 (fifoDepthLog2),
        .maxBurst      (maxBurst)
    ) transmissionTop_i (
        .dataClk      (dataClk),
        .fifoReadClk  (fifoReadClk),
        .rst          (rst),
        .enableData   (enableData),
        .averagingExp (averagingExp),
        .in           (in),
        .txWord       (txWord),
        .txValid      (txValid),
        .txHeader     (txHeader),
        .overflow     (overflow)
    );

    always #50 dataClk = ~dataClk;
    always @(dataClk) fifoReadClk <= #30 dataClk; // same period and 30 ns behind
    always @(posedge dataClk) cycle <= cycle + 1;

    function automatic logic signed [15:0] sampleAt(input int c, input int k);
        return 16'(baseV[c] + k * stepV[c]);
    endfunction

    task automatic checkWord(input int ch, input logic signed [15:0] actual);
        assert (recvCount[ch] < nAvg) else begin
            $display("%s: more averages than expected on channel %0d", testName, ch);
            errors++;
            return;
        end
        assert (actual == expVal[ch][recvCount[ch]]) else begin
            $display("FAILED %s channel %0d average %0d: expected %0d, actual %0d",
                     testName, ch, recvCount[ch], expVal[ch][recvCount[ch]], actual);
            errors++;
        end
        recvCount[ch]++;
    endtask

    // a channel with visible data at ch's last header must be served before ch comes again
    task automatic roundRobinCheck(input int ch);
        for (int d = 0; d < nOfChannels; d++) begin
            assert (!checkValues || !hadPacket[ch] || d == ch || !busySnap[ch][d]
                    || seenSince[ch][d]) else begin
                $display("%s: channel %0d served twice while channel %0d waited",
                         testName, ch, d);
                errors++;
            end
        end
        for (int e = 0; e < nOfChannels; e++) begin
            seenSince[e][ch] = 1'b1;
        end
        seenSince[ch] = '0;
        hadPacket[ch] = 1'b1;
        for (int d = 0; d < nOfChannels; d++) begin
            busySnap[ch][d] = mask[d] && recvCount[d] < nAvg
                              && runEnd[recvCount[d]] + visibleLag <= cycle;
        end
    endtask

    always @(negedge fifoReadClk) begin
        int ch;
        int len;
        if (rst) begin
            remaining = 0;
        end else if (txValid && txHeader) begin
            ch = int'(txWord.header.channelId);
            len = int'(txWord.header.burstLen);
            assert (remaining == 0) else begin
                $display("%s: header arrived %0d words before the end of a packet",
                         testName, remaining);
                errors++;
            end
            assert (ch < nOfChannels && mask[ch % nOfChannels]) else begin
                $display("%s: header names channel %0d, which is not enabled", testName, ch);
                errors++;
            end
            assert (len >= 1 && len <= maxBurst) else begin
                $display("%s: header burst length %0d out of range", testName, len);
                errors++;
            end
            ch = ch % nOfChannels;
            roundRobinCheck(ch);
            remaining = len;
            curCh = ch;
        end else if (txValid) begin
            assert (remaining > 0) else begin
                $display("%s: data word on the bus without a header", testName);
                errors++;
            end
            if (remaining > 0) begin
                remaining--;
                if (checkValues) begin
                    checkWord(curCh, txWord.data);
                end
            end
        end else begin
            assert (remaining == 0) else begin
                $display("%s: packet cut short with %0d words missing", testName, remaining);
                errors++;
            end
            remaining = 0;
        end
    end

    task automatic applyReset(input int avgExp);
        for (int i = 0; i < 11; i++) begin
            @(posedge dataClk);
            if (i == 0) begin
                rst <= 1'b1;
                enableData <= '0;
                averagingExp <= avgExp[txPkg::averagingExpBitSize-1:0];
            end
            if (i == 8) begin
                rst <= 1'b0; // held for 8 cycles
            end
            @(negedge dataClk);
            assert (i < 2 || (!txValid && !txHeader && overflow == '0)) else begin
                $display("FAILED %s reset: expected valid 0 header 0 overflow %b, actual %b %b %b",
                         testName, {nOfChannels{1'b0}}, txValid, txHeader, overflow);
                errors++;
            end
        end
    endtask

    task automatic runTest(input int avgExp, input int ovf);
        int runLen;
        longint sum;
        int timer;
        logic done;
        applyReset(avgExp);
        runLen = 1 << avgExp;
        checkValues = (ovf == 0); // dropped words make the values unpredictable
        hadPacket = '0;
        for (int c = 0; c < nOfChannels; c++) begin
            recvCount[c] = 0;
            seenSince[c] = '0;
            busySnap[c] = '0;
        end
        for (int j = 0; j < nAvg; j++) begin
            runEnd[j] = 32'h3fff_ffff;
            for (int c = 0; c < nOfChannels; c++) begin
                sum = 0;
                for (int i = 0; i < runLen; i++) begin
                    sum += sampleAt(c, j * runLen + i);
                end
                expVal[c][j] = 16'(sum >>> avgExp); // floor mean cut to 16 bits
            end
        end
        for (int k = 0; k < nAvg * runLen; k++) begin
            @(posedge dataClk);
            enableData <= mask;
            for (int c = 0; c < nOfChannels; c++) begin
                in[c*txPkg::dataBitSize +: txPkg::dataBitSize] <= sampleAt(c, k);
            end
            if (k % runLen == runLen - 1) begin
                runEnd[k / runLen] = cycle;
            end
        end
        @(posedge dataClk);
        enableData <= '0;
        done = 1'b0;
        for (timer = 0; timer < 20000 && !done; timer++) begin
            @(negedge dataClk);
            done = 1'b1;
            for (int c = 0; c < nOfChannels; c++) begin
                if (ovf != 0 && mask[c] && !overflow[c]) begin
                    done = 1'b0;
                end
                if (ovf == 0 && mask[c] && recvCount[c] < nAvg) begin
                    done = 1'b0;
                end
            end
        end
        assert (done) else begin
            $display("%s: timeout waiting for %s", testName,
                     (ovf != 0) ? "the overflow flags" : "the expected averages");
            errors++;
        end
        assert (ovf != 0 || overflow == '0) else begin
            $display("FAILED %s overflow flags: expected %b, actual %b", testName,
                     {nOfChannels{1'b0}}, overflow);
            errors++;
        end
    endtask

    initial begin
        int fd;
        int rc;
        int n;
        int avgExp;
        int ovf;
        string line;
        rst = 1'b1;
        enableData = '0;
        averagingExp = '0;
        in = '0;
        mask = '0;
        checkValues = 1'b0;
        nAvg = 0;
        testName = "startup";
        fd = $fopen("tb/transmission_tests.txt", "r");
        assert (fd != 0) else begin
            $display("could not open tb/transmission_tests.txt");
            errors++;
        end
        while (fd != 0 && !$feof(fd)) begin
            rc = $fgets(line, fd);
            if (rc == 0 || line.len() < 2 || line.substr(0, 0) == "#") begin
                continue;
            end
            n = $sscanf(line, "%s %d %b %d %d %d %d %d %d %d %d %d %d", testName, avgExp,
                        mask, baseV[0], stepV[0], baseV[1], stepV[1], baseV[2], stepV[2],
                        baseV[3], stepV[3], nAvg, ovf);
            assert (n == 13 && nAvg <= maxAvg) else begin
                $display("malformed test line: %s", line);
                errors++;
                continue;
            end
            testsRun++;
            runTest(avgExp, ovf);
        end
        if (fd != 0) begin
            $fclose(fd);
        end
        assert (testsRun > 0) else begin
            $display("no tests were read from the test file");
            errors++;
        end
        $display("%0d tests run, %0d errors", testsRun, errors);
        if (errors == 0) begin
            $display("** PASS **");
        end else begin
            $display("** FAIL **");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* tb/transmission_tests.txt */
# name exp mask(ch3..ch0) base0 step0 base1 step1 base2 step2 base3 step3 averages overflow
# sample k of a channel is base + k*step, cut to 16 bits; overflow 1 expects every FIFO to overrun
exp0Ramps 0 1111 -20 1 300 -7 -4000 13 5 -2 40 0
exp2Ramps 2 1111 -100 3 250 -11 -32000 5 7 1 30 0
exp4Ramps 4 1111 -500 -3 1000 9 17 -1 -32768 41 20 0
twoChannels 2 0101 -9 2 0 0 30000 -5 0 0 25 0
singleChannel 3 1000 0 0 0 0 0 0 -1 -1 30 0
wrapRamp 2 0011 32760 1 -32765 -1 0 0 0 0 10 0
overflowAll 0 1111 1 1 2 2 -3 -3 4 4 300 1

/* flist.f */
hw/txPkg.sv
hw/sampleAverager.sv
hw/asyncSampleFifo.sv
hw/channelDataHandler.sv
hw/transmitArbiter.sv
hw/transmissionTop.sv
tb/transmissionTop_tb.sv
